// File: Makefile
# Verilator flow for the data-memory path

TOP := lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: list.f
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/obi_manager.sv
logic/obi_sram.sv
logic/lsu_top.sv
verification/lsu_tb.sv

// File: logic/lsu_align.sv
/*
  alignment stage between the load/store unit and the OBI manager
  builds word requests with byte enables and formats load data on the way back
  misaligned or unknown accesses are answered here without a bus transaction
*/

module lsu_align import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // typed access from the core
    input  logic                  lsu_valid_i,
    output logic                  lsu_ready_o,
    input  lsu_op_e               lsu_op_i,
    input  logic [ADDR_WIDTH-1:0] lsu_addr_i,
    input  logic [DATA_WIDTH-1:0] lsu_wdata_i,
    output logic                  lsu_rvalid_o,
    output logic [DATA_WIDTH-1:0] lsu_rdata_o,
    output logic                  lsu_err_o,
    input  logic                  lsu_rready_i,
    // word request to the manager
    output logic                  core_valid_o,
    input  logic                  core_ready_i,
    output logic [ADDR_WIDTH-1:0] core_addr_o,
    output logic                  core_we_o,
    output logic [BE_WIDTH-1:0]   core_be_o,
    output logic [DATA_WIDTH-1:0] core_wdata_o,
    // response from the manager
    input  logic                  resp_valid_i,
    input  logic [DATA_WIDTH-1:0] resp_rdata_i,
    input  logic                  resp_err_i,
    output logic                  resp_ready_o
);

    logic [1:0]            offset;
    logic                  is_store;
    logic [BE_WIDTH-1:0]   be_base;
    logic [DATA_WIDTH-1:0] wdata_rep;
    logic                  misaligned;
    logic                  illegal;
    logic                  local_err;
    logic                  accept;
    logic                  busy_q;
    logic                  err_pend_q;
    lsu_op_e               op_q;
    logic [1:0]            off_q;
    logic [DATA_WIDTH-1:0] shifted;
    logic [DATA_WIDTH-1:0] load_data;

    assign offset = lsu_addr_i[1:0];

    // opcode decode
    always_comb begin
        is_store   = 1'b0;
        be_base    = '0;
        wdata_rep  = lsu_wdata_i;
        misaligned = 1'b0;
        illegal    = 1'b0;
        case (lsu_op_i)
            LB, LBU: be_base = 4'b0001;
            LH, LHU: begin
                be_base    = 4'b0011;
                misaligned = offset[0];
            end
            LW: begin
                be_base    = 4'b1111;
                misaligned = (offset != 2'd0);
            end
            SB: begin
                is_store  = 1'b1;
                be_base   = 4'b0001;
                // byte copied to every lane
                wdata_rep = {4{lsu_wdata_i[7:0]}};
            end
            SH: begin
                is_store   = 1'b1;
                be_base    = 4'b0011;
                wdata_rep  = {2{lsu_wdata_i[15:0]}};
                misaligned = offset[0];
            end
            SW: begin
                is_store   = 1'b1;
                be_base    = 4'b1111;
                misaligned = (offset != 2'd0);
            end
            default: illegal = 1'b1;
        endcase
    end

    assign local_err = misaligned | illegal;

    // one access in flight, so ready drops until the response is taken
    assign lsu_ready_o = ~busy_q & core_ready_i;
    assign accept      = lsu_valid_i & lsu_ready_o;

    // bad accesses never reach the bus
    assign core_valid_o = lsu_valid_i & ~busy_q & ~local_err;
    assign core_addr_o  = {lsu_addr_i[ADDR_WIDTH-1:2], 2'b00};
    assign core_we_o    = is_store;
    assign core_be_o    = be_base << offset;
    assign core_wdata_o = wdata_rep;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            err_pend_q <= 1'b0;
        end else begin
            if (accept) begin
                busy_q     <= 1'b1;
                err_pend_q <= local_err;
            end else if (lsu_rvalid_o && lsu_rready_i) begin
                busy_q     <= 1'b0;
                err_pend_q <= 1'b0;
            end
        end
    end

    // opcode and lane kept for the response
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= lsu_op_i;
            off_q <= offset;
        end
    end

    // addressed lane moved down to bit 0
    assign shifted = resp_rdata_i >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            LB:      load_data = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     load_data = {24'd0, shifted[7:0]};
            LH:      load_data = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     load_data = {16'd0, shifted[15:0]};
            LW:      load_data = shifted;
            // stores return no data
            default: load_data = '0;
        endcase
    end

    assign lsu_rvalid_o = err_pend_q | resp_valid_i;
    assign lsu_err_o    = err_pend_q | resp_err_i;
    assign lsu_rdata_o  = lsu_err_o ? '0 : load_data;
    assign resp_ready_o = lsu_rready_i & ~err_pend_q;

    // a forwarded request always enables some lane
    a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        core_valid_o && core_ready_i |-> core_be_o != '0)
        else $error("lsu_align: request forwarded with empty byte enable");

endmodule

// File: logic/lsu_pkg.sv
/*
  shared types for the load/store data path
  imported by the alignment stage, the OBI manager, the memory and the top level
*/

package lsu_pkg;

    // register and bus data width
    localparam int DATA_WIDTH = 32;

    // one enable per byte lane
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // load/store opcodes
    // low bits follow the RISC-V funct3 encoding
    // bit 3 marks a store
    typedef enum logic [3:0] {
        // signed byte load
        LB  = 4'b0000,
        // signed half load
        LH  = 4'b0001,
        // word load
        LW  = 4'b0010,
        // unsigned byte load
        LBU = 4'b0100,
        // unsigned half load
        LHU = 4'b0101,
        // byte store
        SB  = 4'b1000,
        // half store
        SH  = 4'b1001,
        // word store
        SW  = 4'b1010
    } lsu_op_e;

    // OBI manager FSM
    typedef enum logic [1:0] {
        // free, waiting for a core request
        IDLE       = 2'b00,
        // req high, waiting for gnt
        REQUESTING = 2'b01,
        // granted, waiting for rvalid
        WAITING    = 2'b10,
        // response held until the core takes it
        RESPONDING = 2'b11
    } obi_state_e;

endpackage

// File: logic/lsu_top.sv
/*
  data-memory path top level
  alignment stage -> OBI manager -> OBI memory, parameters set here
*/

module lsu_top import lsu_pkg::*; #(
    parameter int         ADDR_WIDTH = 32,
    parameter int         MEM_WORDS  = 256,
    parameter logic [3:0] STALL_SEED = 4'b1011
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lsu_valid_i,
    output logic                  lsu_ready_o,
    input  lsu_op_e               lsu_op_i,
    input  logic [ADDR_WIDTH-1:0] lsu_addr_i,
    input  logic [DATA_WIDTH-1:0] lsu_wdata_i,
    output logic                  lsu_rvalid_o,
    output logic [DATA_WIDTH-1:0] lsu_rdata_o,
    output logic                  lsu_err_o,
    input  logic                  lsu_rready_i
);

    // alignment stage <-> manager
    logic                  core_valid;
    logic                  core_ready;
    logic [ADDR_WIDTH-1:0] core_addr;
    logic                  core_we;
    logic [BE_WIDTH-1:0]   core_be;
    logic [DATA_WIDTH-1:0] core_wdata;
    logic                  resp_valid;
    logic [DATA_WIDTH-1:0] resp_rdata;
    logic                  resp_err;
    logic                  resp_ready;

    // OBI bus
    logic                  obi_req;
    logic                  obi_gnt;
    logic [ADDR_WIDTH-1:0] obi_addr;
    logic                  obi_we;
    logic [BE_WIDTH-1:0]   obi_be;
    logic [DATA_WIDTH-1:0] obi_wdata;
    logic [DATA_WIDTH-1:0] obi_rdata;
    logic                  obi_rvalid;
    logic                  obi_err;

    lsu_align #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_valid_i  (lsu_valid_i),
        .lsu_ready_o  (lsu_ready_o),
        .lsu_op_i     (lsu_op_i),
        .lsu_addr_i   (lsu_addr_i),
        .lsu_wdata_i  (lsu_wdata_i),
        .lsu_rvalid_o (lsu_rvalid_o),
        .lsu_rdata_o  (lsu_rdata_o),
        .lsu_err_o    (lsu_err_o),
        .lsu_rready_i (lsu_rready_i),
        .core_valid_o (core_valid),
        .core_ready_i (core_ready),
        .core_addr_o  (core_addr),
        .core_we_o    (core_we),
        .core_be_o    (core_be),
        .core_wdata_o (core_wdata),
        .resp_valid_i (resp_valid),
        .resp_rdata_i (resp_rdata),
        .resp_err_i   (resp_err),
        .resp_ready_o (resp_ready)
    );

    obi_manager #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_manager (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_valid_i (core_valid),
        .core_ready_o (core_ready),
        .core_addr_i  (core_addr),
        .core_we_i    (core_we),
        .core_be_i    (core_be),
        .core_wdata_i (core_wdata),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .resp_err_o   (resp_err),
        .resp_ready_i (resp_ready),
        .obi_req_o    (obi_req),
        .obi_gnt_i    (obi_gnt),
        .obi_addr_o   (obi_addr),
        .obi_we_o     (obi_we),
        .obi_be_o     (obi_be),
        .obi_wdata_o  (obi_wdata),
        .obi_rdata_i  (obi_rdata),
        .obi_rvalid_i (obi_rvalid),
        .obi_err_i    (obi_err)
    );

    obi_sram #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MEM_WORDS (MEM_WORDS),
        .STALL_SEED(STALL_SEED)
    ) u_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .obi_req_i    (obi_req),
        .obi_gnt_o    (obi_gnt),
        .obi_addr_i   (obi_addr),
        .obi_we_i     (obi_we),
        .obi_be_i     (obi_be),
        .obi_wdata_i  (obi_wdata),
        .obi_rdata_o  (obi_rdata),
        .obi_rvalid_o (obi_rvalid),
        .obi_err_o    (obi_err)
    );

endmodule

// File: logic/obi_manager.sv
/*
  OBI manager carrying one access at a time
  takes a word request from the alignment stage, runs req/gnt and holds the response
*/

module obi_manager import lsu_pkg::*; #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // request from the alignment stage
    input  logic                  core_valid_i,
    output logic                  core_ready_o,
    input  logic [ADDR_WIDTH-1:0] core_addr_i,
    input  logic                  core_we_i,
    input  logic [BE_WIDTH-1:0]   core_be_i,
    input  logic [DATA_WIDTH-1:0] core_wdata_i,
    // response back to the alignment stage
    output logic                  resp_valid_o,
    output logic [DATA_WIDTH-1:0] resp_rdata_o,
    output logic                  resp_err_o,
    input  logic                  resp_ready_i,
    // OBI bus
    output logic                  obi_req_o,
    input  logic                  obi_gnt_i,
    output logic [ADDR_WIDTH-1:0] obi_addr_o,
    output logic                  obi_we_o,
    output logic [BE_WIDTH-1:0]   obi_be_o,
    output logic [DATA_WIDTH-1:0] obi_wdata_o,
    input  logic [DATA_WIDTH-1:0] obi_rdata_i,
    input  logic                  obi_rvalid_i,
    input  logic                  obi_err_i
);

    obi_state_e            state_q;
    obi_state_e            state_d;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  we_q;
    logic [BE_WIDTH-1:0]   be_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  err_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (core_valid_i) state_d = REQUESTING;
            REQUESTING: if (obi_gnt_i) state_d = WAITING;
            WAITING:    if (obi_rvalid_i) state_d = RESPONDING;
            RESPONDING: if (resp_ready_i) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request latched at acceptance and held through the stall
    always_ff @(posedge clk) begin
        if (state_q == IDLE && core_valid_i) begin
            addr_q  <= core_addr_i;
            we_q    <= core_we_i;
            be_q    <= core_be_i;
            wdata_q <= core_wdata_i;
        end
    end

    // response latched on rvalid
    always_ff @(posedge clk) begin
        if (state_q == WAITING && obi_rvalid_i) begin
            rdata_q <= obi_rdata_i;
            err_q   <= obi_err_i;
        end
    end

    assign core_ready_o = (state_q == IDLE);

    // bus side driven from the latched request
    assign obi_req_o   = (state_q == REQUESTING);
    assign obi_addr_o  = addr_q;
    assign obi_we_o    = we_q;
    assign obi_be_o    = be_q;
    assign obi_wdata_o = wdata_q;

    assign resp_valid_o = (state_q == RESPONDING);
    assign resp_rdata_o = rdata_q;
    assign resp_err_o   = err_q;

    // OBI rule: request stays up and unchanged until granted
    property p_req_stable;
        @(posedge clk) disable iff (!rst_n)
        obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o)
            && $stable(obi_be_o) && $stable(obi_wdata_o);
    endproperty

    a_req_stable: assert property (p_req_stable)
        else $error("obi_manager: request changed before grant");

    // subordinate answers only the granted access
    a_rvalid_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        obi_rvalid_i |-> state_q == WAITING)
        else $error("obi_manager: rvalid outside WAITING");

endmodule

// File: logic/obi_sram.sv
/*
  OBI word memory used as the bus subordinate
  grants after a pseudo-random stall and flags accesses past its last word
*/

module obi_sram import lsu_pkg::*; #(
    parameter int         ADDR_WIDTH = 32,
    parameter int         MEM_WORDS  = 256,
    parameter logic [3:0] STALL_SEED = 4'b1011
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  obi_req_i,
    output logic                  obi_gnt_o,
    input  logic [ADDR_WIDTH-1:0] obi_addr_i,
    input  logic                  obi_we_i,
    input  logic [BE_WIDTH-1:0]   obi_be_i,
    input  logic [DATA_WIDTH-1:0] obi_wdata_i,
    output logic [DATA_WIDTH-1:0] obi_rdata_o,
    output logic                  obi_rvalid_o,
    output logic                  obi_err_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];
    logic [3:0]            lfsr_q;
    logic                  stalling_q;
    logic [1:0]            wait_q;
    logic [ADDR_WIDTH-3:0] word_idx;
    logic [IDX_W-1:0]      idx;
    logic                  in_range;

    assign word_idx = obi_addr_i[ADDR_WIDTH-1:2];
    assign idx      = word_idx[IDX_W-1:0];
    assign in_range = word_idx < (ADDR_WIDTH-2)'(MEM_WORDS);

    // x^4 + x^3 + 1 LFSR stepping every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= STALL_SEED;
        end else begin
            lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
        end
    end

    // zero stall grants in the request cycle
    // otherwise count down the picked stall
    assign obi_gnt_o = obi_req_i & (stalling_q ? (wait_q == 2'd0) : (lfsr_q[1:0] == 2'd0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stalling_q <= 1'b0;
            wait_q     <= 2'd0;
        end else if (obi_gnt_o) begin
            stalling_q <= 1'b0;
        end else if (obi_req_i && !stalling_q) begin
            stalling_q <= 1'b1;
            wait_q     <= lfsr_q[1:0] - 2'd1;
        end else if (stalling_q && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    // byte-enabled write that is dropped when out of range
    always_ff @(posedge clk) begin
        if (obi_gnt_o && obi_we_i && in_range) begin
            for (int b = 0; b < BE_WIDTH; b++) begin
                if (obi_be_i[b]) begin
                    mem_q[idx][8*b +: 8] <= obi_wdata_i[8*b +: 8];
                end
            end
        end
    end

    // response one cycle after the grant edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obi_rvalid_o <= 1'b0;
            obi_err_o    <= 1'b0;
        end else begin
            obi_rvalid_o <= obi_gnt_o;
            obi_err_o    <= obi_gnt_o & ~in_range;
        end
    end

    // read data is zero on writes and errors
    always_ff @(posedge clk) begin
        if (obi_gnt_o) begin
            obi_rdata_o <= (!obi_we_i && in_range) ? mem_q[idx] : '0;
        end
    end

    // grant only for a live request
    a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        obi_gnt_o |-> obi_req_i)
        else $error("obi_sram: grant without request");

    // the manager holds req, so the stall never exceeds 3 cycles
    a_stall_bound: assert property (@(posedge clk) disable iff (!rst_n)
        obi_req_i |-> ##[0:3] obi_gnt_o)
        else $error("obi_sram: grant stall too long");

endmodule

// File: verification/lsu_tb.sv
/*
  testbench for the data-memory path
  drives random typed accesses and checks every response against a byte-level
  reference memory with concurrent assertions
*/

module lsu_tb import lsu_pkg::*; ();

    localparam int ADDR_WIDTH   = 32;
    // small memory keeps the preload pass short
    localparam int MEM_WORDS    = 64;
    localparam int N_ACCESS     = 400;
    localparam int RESET_CYCLES = 4;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_ACCESS * 16;
    localparam int BYTE_IDX_W   = $clog2(4 * MEM_WORDS);

    logic                  clk;
    logic                  rst_n;
    logic                  lsu_valid_i;
    logic                  lsu_ready_o;
    lsu_op_e               lsu_op_i;
    logic [ADDR_WIDTH-1:0] lsu_addr_i;
    logic [DATA_WIDTH-1:0] lsu_wdata_i;
    logic                  lsu_rvalid_o;
    logic [DATA_WIDTH-1:0] lsu_rdata_o;
    logic                  lsu_err_o;
    logic                  lsu_rready_i;

    integer seed;
    int     issued    = 0;
    int     n_acc     = 0;
    int     n_resp    = 0;
    int     cycle_cnt = 0;
    // how often each behavior was reached
    int     n_word_rt = 0;
    int     n_sub     = 0;
    int     n_misal   = 0;
    int     n_oor     = 0;
    int     n_stall   = 0;

    lsu_op_e               last_op;
    logic [ADDR_WIDTH-1:0] last_addr;
    logic [ADDR_WIDTH-1:0] last_sw_addr;

    // reference memory, one entry per byte
    logic [7:0]            mem_model [4*MEM_WORDS];
    // expected responses in order, {err, rdata}
    logic [DATA_WIDTH:0]   exp_q [$];
    logic                  exp_valid = 1'b0;
    logic                  exp_err   = 1'b0;
    logic [DATA_WIDTH-1:0] exp_rdata = '0;

    lsu_top #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .lsu_valid_i  (lsu_valid_i),
        .lsu_ready_o  (lsu_ready_o),
        .lsu_op_i     (lsu_op_i),
        .lsu_addr_i   (lsu_addr_i),
        .lsu_wdata_i  (lsu_wdata_i),
        .lsu_rvalid_o (lsu_rvalid_o),
        .lsu_rdata_o  (lsu_rdata_o),
        .lsu_err_o    (lsu_err_o),
        .lsu_rready_i (lsu_rready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic int access_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            default:     return 4;
        endcase
    endfunction

    function automatic logic writes_memory(input lsu_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    function automatic lsu_op_e op_from_index(input int idx);
        case (idx)
            0:       return LB;
            1:       return LH;
            2:       return LW;
            3:       return LBU;
            4:       return LHU;
            5:       return SB;
            6:       return SH;
            default: return SW;
        endcase
    endfunction

    // load of the same width as op
    function automatic lsu_op_e load_for(input lsu_op_e op, input logic uns);
        case (access_size(op))
            1:       return uns ? LBU : LB;
            2:       return uns ? LHU : LH;
            default: return LW;
        endcase
    endfunction

    // model update and expected response for one accepted access
    task automatic record_access(input lsu_op_e op, input logic [ADDR_WIDTH-1:0] addr,
                                 input logic [DATA_WIDTH-1:0] wdata);
        int                    size;
        int                    i;
        logic                  err;
        logic [DATA_WIDTH-1:0] value;
        size  = access_size(op);
        value = '0;
        // halves on odd bytes, words off a word boundary
        err   = (addr % size) != 0;
        if (err) begin
            n_misal++;
        end else if (addr >= 4 * MEM_WORDS) begin
            err = 1'b1;
            n_oor++;
        end
        if (!err && writes_memory(op)) begin
            for (i = 0; i < size; i++) begin
                mem_model[BYTE_IDX_W'(addr + i)] = 8'(wdata >> (8 * i));
            end
            if (op == SW) begin
                last_sw_addr = addr;
            end
        end else if (!err) begin
            for (i = 0; i < size; i++) begin
                value = value | (DATA_WIDTH'(mem_model[BYTE_IDX_W'(addr + i)]) << (8 * i));
            end
            // sign fill for LB and LH
            if ((op == LB || op == LH) && value[8*size-1]) begin
                value = value | ~((32'd1 << (8 * size)) - 32'd1);
            end
            if (op == LW && addr == last_sw_addr) begin
                n_word_rt++;
            end
            if (op != LW) begin
                n_sub++;
            end
        end
        exp_q.push_back({err, value});
    endtask

    // next access onto the input pins
    task automatic pick_access(input int k);
        int                    sel;
        int                    size;
        logic [ADDR_WIDTH-1:0] word;
        logic [ADDR_WIDTH-1:0] addr;
        lsu_op_e               op;
        if (k < MEM_WORDS) begin
            // preload pass, every word gets a defined value
            op   = SW;
            addr = ADDR_WIDTH'(4 * k);
        end else begin
            sel  = {$random(seed)} % 16;
            op   = op_from_index({$random(seed)} % 8);
            word = {$random(seed)} % MEM_WORDS;
            if (sel < 4 && writes_memory(last_op)) begin
                // read back what the last store wrote
                op   = load_for(last_op, ($random(seed) & 1) != 0);
                addr = last_addr;
            end else begin
                size = access_size(op);
                case (sel)
                    // odd byte, misaligned for halves and words
                    4, 5:    addr = 4 * word + ((($random(seed) & 1) != 0) ? 1 : 3);
                    6:       addr = 4 * MEM_WORDS + ({$random(seed)} % 4096);
                    7:       addr = {$random(seed)} | 32'h8000_0000;
                    default: addr = 4 * word + ({$random(seed)} % 4);
                endcase
                if (sel != 4 && sel != 5) begin
                    addr = addr & ~ADDR_WIDTH'(size - 1);
                end
            end
        end
        lsu_op_i    = op;
        lsu_addr_i  = addr;
        lsu_wdata_i = $random(seed);
        last_op     = op;
        last_addr   = addr;
    endtask

    // handshakes seen at the clock edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (lsu_rvalid_o && !lsu_rready_i) begin
                n_stall++;
            end
            if (lsu_rvalid_o && lsu_rready_i && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                n_resp++;
            end
            if (lsu_valid_i && lsu_ready_o) begin
                record_access(lsu_op_i, lsu_addr_i, lsu_wdata_i);
                n_acc++;
            end
            exp_valid <= exp_q.size() > 0;
            exp_err   <= (exp_q.size() > 0) ? exp_q[0][DATA_WIDTH] : 1'b0;
            exp_rdata <= (exp_q.size() > 0) ? exp_q[0][DATA_WIDTH-1:0] : '0;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == CYCLE_LIMIT) begin
            stop_with_error($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                cycle_cnt, n_resp, N_ACCESS));
        end
    end

    initial begin
        seed         = 36043;
        rst_n        = 1'b0;
        lsu_valid_i  = 1'b0;
        lsu_op_i     = LW;
        lsu_addr_i   = '0;
        lsu_wdata_i  = '0;
        lsu_rready_i = 1'b0;
        last_op      = LW;
        last_addr    = '0;
        last_sw_addr = '1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // valid stays up, a new access follows each acceptance
        while (n_acc < N_ACCESS) begin
            // rready low about one cycle in four
            lsu_rready_i = ($random(seed) & 3) != 0;
            if (n_acc == issued && issued < N_ACCESS) begin
                pick_access(issued);
                lsu_valid_i = 1'b1;
                issued++;
            end
            @(negedge clk);
        end
        lsu_valid_i = 1'b0;
        while (n_resp < n_acc) begin
            lsu_rready_i = ($random(seed) & 3) != 0;
            @(negedge clk);
        end
        @(negedge clk);
        if (n_resp == N_ACCESS && exp_q.size() == 0 && n_word_rt > 0 && n_sub > 0
            && n_misal > 0 && n_oor > 0 && n_stall > 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_error($sformatf(
                "run incomplete: %0d responses, %0d pending, reached %0d/%0d/%0d/%0d/%0d",
                n_resp, exp_q.size(), n_word_rt, n_sub, n_misal, n_oor, n_stall));
        end
    end

    // every response answers an accepted access
    a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid_o |-> exp_valid)
        else stop_with_error($sformatf("[FAIL] %0t: response with no access outstanding",
            $time));

    a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid_o && exp_valid && !exp_err |-> !lsu_err_o && lsu_rdata_o == exp_rdata)
        else stop_with_error($sformatf("[FAIL] %0t: got err %0b rdata %h, expected rdata %h",
            $time, $sampled(lsu_err_o), $sampled(lsu_rdata_o), $sampled(exp_rdata)));

    // misaligned and out of range
    a_resp_err: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid_o && exp_valid && exp_err |-> lsu_err_o && lsu_rdata_o == '0)
        else stop_with_error($sformatf("[FAIL] %0t: expected error, got err %0b rdata %h",
            $time, $sampled(lsu_err_o), $sampled(lsu_rdata_o)));

    // response frozen while the requester stalls
    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid_o && !lsu_rready_i |=>
            lsu_rvalid_o && $stable(lsu_rdata_o) && $stable(lsu_err_o))
        else stop_with_error($sformatf("[FAIL] %0t: response changed under back-pressure",
            $time));

    a_busy_ready: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvalid_o |-> !lsu_ready_o)
        else stop_with_error($sformatf("[FAIL] %0t: ready high with a response pending",
            $time));

    a_reset_state: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !lsu_rvalid_o && lsu_ready_o)
        else stop_with_error($sformatf("[FAIL] %0t: rvalid %0b ready %0b around reset",
            $time, $sampled(lsu_rvalid_o), $sampled(lsu_ready_o)));

endmodule
